// ==== src/codec_pkg.sv ====
`default_nettype none

package codec_pkg;

    // Control register addresses of the codec
    typedef enum logic [6:0] {
        REG_LLINE_IN = 7'h00,
        REG_RLINE_IN = 7'h01,
        REG_LHP_OUT  = 7'h02,
        REG_RHP_OUT  = 7'h03,
        REG_ANA_PATH = 7'h04,  // Analogue audio path
        REG_DIG_PATH = 7'h05,  // Digital audio path
        REG_PWR_DOWN = 7'h06,
        REG_IF_FMT   = 7'h07,  // Digital audio interface format
        REG_SAMPLING = 7'h08,
        REG_ACTIVE   = 7'h09,
        REG_RESET    = 7'h0F
    } codec_reg_e;

    // One register write, address plus 9-bit data
    typedef struct packed {
        logic [6:0] addr;
        logic [8:0] data;
    } codec_word_t;

    localparam logic [7:0] CODEC_DEV_ADDR = 8'h34;  // Write address byte

    localparam int INIT_LEN = 7;

    // Power-up order, Active Control goes last
    localparam codec_word_t INIT_TABLE [INIT_LEN] = '{
        '{addr: REG_RESET,    data: 9'h000},
        '{addr: REG_ANA_PATH, data: 9'h015},
        '{addr: REG_DIG_PATH, data: 9'h000},
        '{addr: REG_PWR_DOWN, data: 9'h000},
        '{addr: REG_IF_FMT,   data: 9'h042},
        '{addr: REG_SAMPLING, data: 9'h019},
        '{addr: REG_ACTIVE,   data: 9'h001}
    };

endpackage

`default_nettype wire

// ==== src/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // Wishbone word addresses
    typedef enum logic [1:0] {
        WB_CTRL   = 2'd0,  // Bit 0 starts power-up
        WB_STATUS = 2'd1,  // Read only
        WB_CMD    = 2'd2   // Bits 15:0 hold a codec word
    } wb_reg_e;

    // STATUS bit positions
    localparam int STAT_BUSY      = 0;
    localparam int STAT_INIT_DONE = 1;
    localparam int STAT_NACK      = 2;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_INIT_ISSUE,
        SEQ_INIT_WAIT,
        SEQ_CMD_ISSUE,
        SEQ_CMD_WAIT
    } seq_state_e;

    // Each phase lasts two SCL quarters
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_BIT_LOW,
        PH_BIT_HIGH,
        PH_STOP_LOW,
        PH_STOP_HIGH,
        PH_GAP
    } i2c_phase_e;

endpackage

`default_nettype wire

// ==== src/i2c_cmd_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface i2c_cmd_if;

    logic                   req;    // Word is valid
    logic                   ready;  // Engine can take a frame
    codec_pkg::codec_word_t word;
    logic                   done;   // One cycle after stop
    logic                   nack;   // Valid with done

    modport master (
        output req,
        output word,
        input  ready,
        input  done,
        input  nack
    );

    modport engine (
        input  req,
        input  word,
        output ready,
        output done,
        output nack
    );

endinterface

`default_nettype wire

// ==== src/wb_cfg_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module wb_cfg_regs (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_wb_cyc,
    input  wire                    i_wb_stb,
    input  wire                    i_wb_we,
    input  ctrl_pkg::wb_reg_e      i_wb_adr,
    input  wire  [31:0]            i_wb_dat,
    output logic [31:0]            o_wb_dat,
    output logic                   o_wb_ack,
    output logic                   o_start,
    output logic                   o_slot_valid,
    output codec_pkg::codec_word_t o_slot_word,
    output logic                   o_nack_clr,
    input  wire                    i_slot_take,
    input  wire                    i_busy,
    input  wire                    i_init_done,
    input  wire                    i_nack
);

    logic                   wb_req;
    logic                   cmd_wr;
    logic                   ctrl_wr;
    logic                   accept;
    logic [31:0]            status_w;
    logic                   ack_r;
    logic                   start_r;
    logic                   nack_clr_r;
    logic                   slot_valid_r;
    logic [31:0]            dat_r;
    codec_pkg::codec_word_t slot_word_r;

    assign wb_req  = i_wb_cyc && i_wb_stb && !ack_r;  // New request only
    assign cmd_wr  = i_wb_we && (i_wb_adr == ctrl_pkg::WB_CMD);
    assign ctrl_wr = i_wb_we && (i_wb_adr == ctrl_pkg::WB_CTRL);

    // A full slot holds off the CMD write
    assign accept = wb_req && !(cmd_wr && slot_valid_r);

    always_comb begin
        status_w = '0;
        status_w[ctrl_pkg::STAT_BUSY]      = i_busy || slot_valid_r;
        status_w[ctrl_pkg::STAT_INIT_DONE] = i_init_done;
        status_w[ctrl_pkg::STAT_NACK]      = i_nack;
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            ack_r        <= 1'b0;
            start_r      <= 1'b0;
            nack_clr_r   <= 1'b0;
            slot_valid_r <= 1'b0;
        end else begin
            ack_r      <= accept;
            start_r    <= accept && ctrl_wr && i_wb_dat[0] && !i_busy;  // Ignored while busy
            nack_clr_r <= accept && ctrl_wr;
            if (accept && cmd_wr)
                slot_valid_r <= 1'b1;
            else if (i_slot_take)
                slot_valid_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && cmd_wr)
            slot_word_r <= i_wb_dat[15:0];
        if (accept)
            dat_r <= (!i_wb_we && i_wb_adr == ctrl_pkg::WB_STATUS) ? status_w : '0;
    end

    assign o_wb_ack     = ack_r;
    assign o_wb_dat     = dat_r;
    assign o_start      = start_r;
    assign o_nack_clr   = nack_clr_r;
    assign o_slot_valid = slot_valid_r;
    assign o_slot_word  = slot_word_r;

    // Ack answers a live cycle
    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb));

    // Sequencer takes only a full slot
    a_take_full: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_slot_take |-> o_slot_valid);

endmodule

`default_nettype wire

// ==== src/codec_write_seq.sv ====
`default_nettype none
`timescale 1ns/1ps

module codec_write_seq (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_start,
    input  wire                    i_slot_valid,
    input  codec_pkg::codec_word_t i_slot_word,
    input  wire                    i_nack_clr,
    output logic                   o_slot_take,
    output logic                   o_busy,
    output logic                   o_init_done,
    output logic                   o_nack,
    i2c_cmd_if.master              cmd
);

    localparam int IDX_W = $clog2(codec_pkg::INIT_LEN);

    ctrl_pkg::seq_state_e   state_r;
    logic [IDX_W-1:0]       idx_r;      // Power-up table position
    logic                   init_done_r;
    logic                   nack_r;
    logic                   in_init;
    codec_pkg::codec_word_t host_word_r;

    assign in_init = (state_r == ctrl_pkg::SEQ_INIT_ISSUE) ||
                     (state_r == ctrl_pkg::SEQ_INIT_WAIT);

    assign cmd.req  = (state_r == ctrl_pkg::SEQ_INIT_ISSUE) ||
                      (state_r == ctrl_pkg::SEQ_CMD_ISSUE);
    assign cmd.word = in_init ? codec_pkg::INIT_TABLE[idx_r] : host_word_r;

    // Start wins over a pending slot
    assign o_slot_take = (state_r == ctrl_pkg::SEQ_IDLE) && !i_start && i_slot_valid;
    assign o_busy      = (state_r != ctrl_pkg::SEQ_IDLE);
    assign o_init_done = init_done_r;
    assign o_nack      = nack_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r     <= ctrl_pkg::SEQ_IDLE;
            idx_r       <= '0;
            init_done_r <= 1'b0;
            nack_r      <= 1'b0;
        end else begin
            case (state_r)
                ctrl_pkg::SEQ_IDLE: begin
                    if (i_start) begin
                        idx_r       <= '0;
                        init_done_r <= 1'b0;
                        state_r     <= ctrl_pkg::SEQ_INIT_ISSUE;
                    end else if (i_slot_valid) begin
                        state_r <= ctrl_pkg::SEQ_CMD_ISSUE;
                    end
                end
                ctrl_pkg::SEQ_INIT_ISSUE: begin
                    if (cmd.ready)
                        state_r <= ctrl_pkg::SEQ_INIT_WAIT;
                end
                ctrl_pkg::SEQ_INIT_WAIT: begin
                    if (cmd.done) begin
                        if (idx_r == IDX_W'(codec_pkg::INIT_LEN - 1)) begin
                            init_done_r <= 1'b1;  // Active Control written
                            state_r     <= ctrl_pkg::SEQ_IDLE;
                        end else begin
                            idx_r   <= idx_r + 1'b1;
                            state_r <= ctrl_pkg::SEQ_INIT_ISSUE;
                        end
                    end
                end
                ctrl_pkg::SEQ_CMD_ISSUE: begin
                    if (cmd.ready)
                        state_r <= ctrl_pkg::SEQ_CMD_WAIT;
                end
                ctrl_pkg::SEQ_CMD_WAIT: begin
                    if (cmd.done)
                        state_r <= ctrl_pkg::SEQ_IDLE;
                end
                default: state_r <= ctrl_pkg::SEQ_IDLE;
            endcase

            // Sticky until a CTRL write
            if (cmd.done && cmd.nack)
                nack_r <= 1'b1;
            else if (i_nack_clr)
                nack_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_slot_take)
            host_word_r <= i_slot_word;
    end

    // Engine finishes only a frame that was handed over
    a_done_in_wait: assert property (@(posedge i_clk) disable iff (i_rst_n)
        cmd.done |-> (state_r inside {ctrl_pkg::SEQ_INIT_WAIT, ctrl_pkg::SEQ_CMD_WAIT}));

endmodule

`default_nettype wire

// ==== src/i2c_write_engine.sv ====
`default_nettype none
`timescale 1ns/1ps

module i2c_write_engine #(
    parameter int CLK_DIV = 4  // Clocks per SCL quarter
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_sda,
    output logic       o_scl,
    output logic       o_sda,
    output logic       o_sda_oen,
    i2c_cmd_if.engine  cmd
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int LAST  = 26;  // 24 data bits and 3 ack slots

    ctrl_pkg::i2c_phase_e phase_r;
    logic [DIV_W-1:0]     div_r;
    logic                 q_r;      // Quarter within the phase
    logic [4:0]           bit_r;
    logic [LAST:0]        frame_r;
    logic                 scl_r;
    logic                 sda_r;
    logic                 oen_r;
    logic                 nack_r;
    logic                 done_r;
    logic                 tick;
    logic                 ack_slot;
    logic                 xfer;

    assign tick     = (div_r == DIV_W'(CLK_DIV - 1));
    assign ack_slot = (bit_r == 5'd8) || (bit_r == 5'd17) || (bit_r == 5'd26);
    assign xfer     = cmd.req && cmd.ready;

    assign cmd.ready = (phase_r == ctrl_pkg::PH_IDLE);
    assign cmd.done  = done_r;
    assign cmd.nack  = nack_r;

    assign o_scl     = scl_r;
    assign o_sda     = sda_r;
    assign o_sda_oen = oen_r;

    // Ack positions carry a 1 so SDA idles high when released
    always_ff @(posedge i_clk) begin
        if (xfer)
            frame_r <= {codec_pkg::CODEC_DEV_ADDR, 1'b1,
                        cmd.word.addr, cmd.word.data[8], 1'b1,
                        cmd.word.data[7:0], 1'b1};
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase_r <= ctrl_pkg::PH_IDLE;
            div_r   <= '0;
            q_r     <= 1'b0;
            bit_r   <= '0;
            scl_r   <= 1'b1;
            sda_r   <= 1'b1;
            oen_r   <= 1'b1;
            nack_r  <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (phase_r == ctrl_pkg::PH_IDLE) begin
                div_r <= '0;
                q_r   <= 1'b0;
                if (xfer) begin
                    sda_r   <= 1'b0;  // Start, SDA falls with SCL high
                    bit_r   <= '0;
                    nack_r  <= 1'b0;
                    phase_r <= ctrl_pkg::PH_START;
                end
            end else if (tick) begin
                div_r <= '0;
                q_r   <= ~q_r;
                case (phase_r)
                    ctrl_pkg::PH_START: begin
                        if (q_r) begin
                            scl_r   <= 1'b0;
                            phase_r <= ctrl_pkg::PH_BIT_LOW;
                        end
                    end
                    ctrl_pkg::PH_BIT_LOW: begin
                        if (!q_r) begin
                            sda_r <= frame_r[LAST - bit_r];  // Data moves mid-low
                            oen_r <= !ack_slot;
                        end else begin
                            scl_r   <= 1'b1;
                            phase_r <= ctrl_pkg::PH_BIT_HIGH;
                        end
                    end
                    ctrl_pkg::PH_BIT_HIGH: begin
                        if (!q_r) begin
                            if (ack_slot && i_sda)
                                nack_r <= 1'b1;
                        end else begin
                            scl_r   <= 1'b0;
                            bit_r   <= bit_r + 1'b1;
                            phase_r <= (bit_r == 5'(LAST)) ? ctrl_pkg::PH_STOP_LOW
                                                            : ctrl_pkg::PH_BIT_LOW;
                        end
                    end
                    ctrl_pkg::PH_STOP_LOW: begin
                        if (!q_r) begin
                            sda_r <= 1'b0;
                            oen_r <= 1'b1;  // Take SDA back after last ack
                        end else begin
                            scl_r   <= 1'b1;
                            phase_r <= ctrl_pkg::PH_STOP_HIGH;
                        end
                    end
                    ctrl_pkg::PH_STOP_HIGH: begin
                        if (!q_r)
                            sda_r <= 1'b1;  // Stop
                        else
                            phase_r <= ctrl_pkg::PH_GAP;
                    end
                    ctrl_pkg::PH_GAP: begin
                        if (q_r) begin
                            done_r  <= 1'b1;
                            phase_r <= ctrl_pkg::PH_IDLE;
                        end
                    end
                    default: phase_r <= ctrl_pkg::PH_IDLE;
                endcase
            end else begin
                div_r <= div_r + 1'b1;
            end
        end
    end

    // SDA edges under high SCL only for start and stop
    a_sda_stable: assert property (@(posedge i_clk) disable iff (i_rst_n)
        ($changed(o_sda) && o_scl) |->
            (phase_r inside {ctrl_pkg::PH_START, ctrl_pkg::PH_STOP_HIGH}));

endmodule

`default_nettype wire

// ==== src/codec_cfg_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module codec_cfg_top #(
    parameter int CLK_DIV = 4
) (
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_wb_cyc,
    input  wire         i_wb_stb,
    input  wire         i_wb_we,
    input  wire  [1:0]  i_wb_adr,
    input  wire  [31:0] i_wb_dat,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack,
    output logic        o_scl,
    output logic        o_sda,
    output logic        o_sda_oen,
    input  wire         i_sda
);

    logic                   start;
    logic                   slot_valid;
    codec_pkg::codec_word_t slot_word;
    logic                   slot_take;
    logic                   nack_clr;
    logic                   busy;
    logic                   init_done;
    logic                   nack;

    i2c_cmd_if cmd_if ();

    wb_cfg_regs u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (ctrl_pkg::wb_reg_e'(i_wb_adr)),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_start      (start),
        .o_slot_valid (slot_valid),
        .o_slot_word  (slot_word),
        .o_nack_clr   (nack_clr),
        .i_slot_take  (slot_take),
        .i_busy       (busy),
        .i_init_done  (init_done),
        .i_nack       (nack)
    );

    codec_write_seq u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .i_slot_valid (slot_valid),
        .i_slot_word  (slot_word),
        .i_nack_clr   (nack_clr),
        .o_slot_take  (slot_take),
        .o_busy       (busy),
        .o_init_done  (init_done),
        .o_nack       (nack),
        .cmd          (cmd_if.master)
    );

    i2c_write_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_eng (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_sda     (i_sda),
        .o_scl     (o_scl),
        .o_sda     (o_sda),
        .o_sda_oen (o_sda_oen),
        .cmd       (cmd_if.engine)
    );

endmodule

`default_nettype wire

// ==== sim/codec_cfg_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module codec_cfg_tb;

    localparam int ACK_LIMIT   = 5000;   // Covers a full power-up of back-pressure
    localparam int FRAME_LIMIT = 20000;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [1:0]  i_wb_adr;
    logic [31:0] i_wb_dat;
    logic [31:0] o_wb_dat;
    logic        o_wb_ack;
    logic        o_scl;
    logic        o_sda;
    logic        o_sda_oen;
    logic        i_sda;

    int   errors    = 0;
    int   checks    = 0;
    int   seed      = 38;
    logic timed_out = 1'b0;

    codec_pkg::codec_word_t exp_q[$];   // Frames still to come
    logic                   nack_q[$];  // Nack flag for each expected frame

    codec_cfg_top #(.CLK_DIV(2)) dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic end_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timed out waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic check_status(input string name, input logic [2:0] got,
                                input logic [2:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input codec_pkg::codec_word_t got,
                              input codec_pkg::codec_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic idle_gap();
        repeat ($random(seed) & 7) @(negedge i_clk);
    endtask

    // One classic cycle started on a falling edge
    task automatic wb_xfer(input logic we, input ctrl_pkg::wb_reg_e adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        n        = 0;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = wdat;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_wb_ack && n < ACK_LIMIT);
        rdat = o_wb_dat;
        if (o_wb_ack)
            @(negedge i_clk);  // Keep stb up through the edge that samples ack
        else
            abort_on_timeout("the Wishbone ack");
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        int          n;
        n = 0;
        while (exp_q.size() > 0 && n < FRAME_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            abort_on_timeout("the expected I2C frames");
        end else begin
            n  = 0;
            rd = 32'h1;
            // Engine still in its gap
            while (rd[ctrl_pkg::STAT_BUSY] && n < 100 && !timed_out) begin
                wb_xfer(1'b0, ctrl_pkg::WB_STATUS, 32'h0, rd);
                n++;
            end
            if (rd[ctrl_pkg::STAT_BUSY] && !timed_out)
                abort_on_timeout("busy to clear");
        end
    endtask

    // Passive frame decoder and ack responder
    initial begin
        logic                   prev_scl;
        logic                   prev_sda;
        logic                   in_frame;
        logic                   nack_now;
        logic [26:0]            shift;
        int                     nbits;
        codec_pkg::codec_word_t got;
        i_sda    = 1'b1;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        in_frame = 1'b0;
        nack_now = 1'b0;
        shift    = '0;
        nbits    = 0;
        forever begin
            @(negedge i_clk);
            if (o_scl && prev_scl && (o_sda != prev_sda)) begin
                if (!o_sda && !in_frame) begin  // Start
                    in_frame = 1'b1;
                    nbits    = 0;
                    nack_now = (nack_q.size() > 0) ? nack_q[0] : 1'b0;
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("A frame started while none was expected");
                    end
                end else if (o_sda && in_frame) begin  // Stop
                    in_frame = 1'b0;
                    if (nbits != 27) begin
                        errors++;
                        $display("A frame carried %0d bits instead of 27", nbits);
                    end else if (exp_q.size() > 0) begin
                        check_byte("device byte", shift[26:19], 8'h34);
                        got.addr = shift[17:11];
                        got.data = {shift[10], shift[8:1]};
                        check_word("frame word", got, exp_q[0]);
                    end
                    if (exp_q.size() > 0) begin
                        void'(exp_q.pop_front());
                        void'(nack_q.pop_front());
                    end
                end else begin
                    errors++;
                    $display("SDA changed while SCL was high outside start and stop");
                end
            end else if (in_frame && o_scl && !prev_scl && nbits < 27) begin
                shift = {shift[25:0], o_sda};
                if (o_sda_oen == (nbits == 8 || nbits == 17 || nbits == 26)) begin
                    errors++;
                    $display("SDA output enable was wrong at bit %0d", nbits);
                end
                nbits++;
            end
            i_sda    = o_sda_oen ? 1'b1 : nack_now;  // Ack pulls low unless a nack is due
            prev_scl = o_scl;
            prev_sda = o_sda;
        end
    end

    initial begin
        int          fd;
        int          a;
        int          b;
        byte         op;
        string       line;
        logic [31:0] rd;
        i_rst_n  = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = 2'd0;
        i_wb_dat = 32'h0;
        fd = $fopen("sim/codec_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file");
        end else begin
            repeat (10) @(negedge i_clk);
            i_rst_n = 1'b0;
            check_status("scl sda oen", {o_scl, o_sda, o_sda_oen}, 3'h7);
            while (!timed_out && $fgets(line, fd) != 0) begin
                op = line.getc(0);
                a  = 0;
                b  = 0;
                if (line.len() > 1)
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                case (op)
                    "S", "K": begin
                        idle_gap();
                        wb_xfer(1'b1, ctrl_pkg::WB_CTRL, (op == "S") ? 32'h1 : 32'h0, rd);
                    end
                    "C": begin
                        idle_gap();
                        wb_xfer(1'b1, ctrl_pkg::WB_CMD, a, rd);
                    end
                    "R": begin
                        idle_gap();
                        wb_xfer(1'b0, ctrl_pkg::WB_STATUS, 32'h0, rd);
                        if (!timed_out)
                            check_status("STATUS", rd[2:0], a[2:0]);
                    end
                    "F": begin
                        exp_q.push_back(a[15:0]);
                        nack_q.push_back(b[0]);
                    end
                    "W": wait_idle();
                    default: ;  // Comment or blank line
                endcase
            end
            $fclose(fd);
        end
        end_run();
    end

endmodule

`default_nettype wire

// ==== sim/codec_trace.txt ====
# Ops: S start, K CTRL write 0, C cmd word, R expected STATUS in hex
# F expected frame word and nack flag, W wait for frames and idle
R 0
S
F 1E00 0
F 0815 0
F 0A00 1
F 0C00 0
F 0E42 0
F 1019 0
F 1201 0
C 0579
F 0579 0
C 077F
F 077F 0
W
R 6
K
R 2
C 0117
F 0117 0
W
R 2

// ==== project.f ====
src/codec_pkg.sv
src/ctrl_pkg.sv
src/i2c_cmd_if.sv
src/wb_cfg_regs.sv
src/codec_write_seq.sv
src/i2c_write_engine.sv
src/codec_cfg_top.sv
sim/codec_cfg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module codec_cfg_tb -f project.f -Mdir obj_dir

out="$(./obj_dir/Vcodec_cfg_tb)"
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
